// File: source/spm_mem_dp.sv
`timescale 1ns/10ps

module spm_mem_dp #(
   parameter int  DW    = 64,           // word width
   parameter int  DEPTH = 32,           // number of words
   localparam int AW    = $clog2(DEPTH) // address width
) (
   input  logic          clk,       // single clock for both ports
   input  logic          rst_n,     // sync reset, active low
   // functional write port
   spm_wr_if.mem         wr,        // from write stage
   output logic          wr_gnt,    // write port free for functional use
   // read port
   input  logic          rd_en,     // read enable
   input  logic [AW-1:0] rd_addr,   // read address
   output logic [DW-1:0] rd_dout,   // read data, one cycle later
   // BIST port
   input  logic          bist_en,   // bist owns the write port
   input  logic          bist_we,   // bist write enable
   input  logic [DW-1:0] bist_wem,  // bist per bit enable
   input  logic [AW-1:0] bist_addr, // bist address
   input  logic [DW-1:0] bist_din   // bist data
);

   logic          ram_wr_en;   // muxed write enable
   logic [DW-1:0] ram_wr_wem;  // muxed bit mask
   logic [AW-1:0] ram_wr_addr; // muxed address
   logic [DW-1:0] ram_wr_din;  // muxed data

   assign wr_gnt = ~bist_en; // bist always wins

   assign ram_wr_en   = bist_en ? bist_we   : wr.wr_en;
   assign ram_wr_wem  = bist_en ? bist_wem  : wr.wr_wem;
   assign ram_wr_addr = bist_en ? bist_addr : wr.wr_addr;
   assign ram_wr_din  = bist_en ? bist_din  : wr.wr_din;

   spm_mem_ram #(
      .DW    (DW),
      .DEPTH (DEPTH)
   ) i_ram (
      .wr_clk  (clk),
      .wr_en   (ram_wr_en),
      .wr_wem  (ram_wr_wem),
      .wr_addr (ram_wr_addr),
      .wr_din  (ram_wr_din),
      .rd_clk  (clk),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_dout (rd_dout)
   );

   // write stage must hold off its pending write while bist owns the port
   a_no_wr_during_bist : assert property (
      @(posedge clk) disable iff (!rst_n) !(wr.wr_en && bist_en)
   );

endmodule

// File: source/spm_mem_ram.sv
`timescale 1ns/10ps

module spm_mem_ram #(
   parameter int  DW    = 64,           // word width
   parameter int  DEPTH = 32,           // number of words
   localparam int AW    = $clog2(DEPTH) // address width
) (
   // write port
   input  logic          wr_clk,  // write clock
   input  logic          wr_en,   // write enable
   input  logic [DW-1:0] wr_wem,  // per bit write enable
   input  logic [AW-1:0] wr_addr, // write address
   input  logic [DW-1:0] wr_din,  // write data
   // read port
   input  logic          rd_clk,  // read clock
   input  logic          rd_en,   // read enable
   input  logic [AW-1:0] rd_addr, // read address
   output logic [DW-1:0] rd_dout  // registered read data
);

   logic [DW-1:0] ram_q [DEPTH]; // storage array

   //##################################################
   // write port, masked per bit
   //##################################################
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         // keep bits outside the mask, take wr_din inside it
         ram_q[wr_addr] <= (ram_q[wr_addr] & ~wr_wem) | (wr_din & wr_wem);
      end
   end

   //##################################################
   // read port, read-first on collision
   //##################################################
   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         rd_dout <= ram_q[rd_addr]; // old word if written on same edge
      end
   end

endmodule

// File: source/spm_pkg.sv
package spm_pkg;

   //##################################################
   // default geometry
   //##################################################
   localparam int spm_default_dw    = 64; // word width in bits
   localparam int spm_default_depth = 32; // number of words
   localparam int spm_byte_w        = 8;  // bits per strobe lane

   //##################################################
   // read response buffer occupancy
   //##################################################
   typedef enum logic [1:0] {
      rd_empty = 2'd0, // nothing buffered
      rd_one   = 2'd1, // head entry only
      rd_two   = 2'd2  // head and tail entries
   } spm_rd_state_e;

endpackage

// File: source/spm_read_stage.sv
`timescale 1ns/10ps

module spm_read_stage #(
   parameter int  DW    = 64,           // word width
   parameter int  DEPTH = 32,           // number of words
   localparam int AW    = $clog2(DEPTH) // address width
) (
   input  logic          clk,         // clock
   input  logic          rst_n,       // sync reset, active low
   // read request channel
   input  logic          rd_valid,    // request valid
   output logic          rd_ready,    // request ready
   input  logic [AW-1:0] rd_addr,     // request address
   // ram read port
   output logic          mem_rd_en,   // ram read enable
   output logic [AW-1:0] mem_rd_addr, // ram read address
   input  logic [DW-1:0] mem_rd_dout, // ram data, cycle after rd_en
   // response channel
   output logic          rsp_valid,   // response valid
   input  logic          rsp_ready,   // response ready
   output logic [DW-1:0] rsp_data     // response data
);

   import spm_pkg::*;

   spm_rd_state_e state_q;    // buffer occupancy
   logic          issue_q;    // read on the ram port now
   logic          ret_q;      // data on mem_rd_dout now
   logic [DW-1:0] head_q;     // oldest response
   logic [DW-1:0] tail_q;     // second response
   logic [1:0]    buf_cnt;    // entries held
   logic [1:0]    fly_cnt;    // reads issued, not yet buffered
   logic          accept;     // read handshake
   logic          push;       // capture ram data
   logic          pop;        // response handshake

   assign buf_cnt = (state_q == rd_two) ? 2'd2 : (state_q == rd_one) ? 2'd1 : 2'd0;
   assign fly_cnt = {1'b0, issue_q} + {1'b0, ret_q};

   assign rd_ready = (buf_cnt + fly_cnt) <= 2'd1; // room for one more
   assign accept   = rd_valid & rd_ready;
   assign push     = ret_q;
   assign pop      = rsp_valid & rsp_ready;

   //##################################################
   // issue pipeline
   //##################################################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         issue_q <= 1'b0;
         ret_q   <= 1'b0;
      end else begin
         issue_q <= accept;
         ret_q   <= issue_q; // ram output valid one edge later
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         mem_rd_addr <= rd_addr;
      end
   end

   assign mem_rd_en = issue_q;

   //##################################################
   // two entry response buffer
   //##################################################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= rd_empty;
      end else begin
         case (state_q)
            rd_empty: if (push) state_q <= rd_one;
            rd_one:   if (push && !pop) state_q <= rd_two;
                      else if (pop && !push) state_q <= rd_empty;
            rd_two:   if (pop && !push) state_q <= rd_one;
            default:  state_q <= rd_empty;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      case (state_q)
         rd_empty: if (push) head_q <= mem_rd_dout;
         rd_one: begin
            if (push && pop) head_q <= mem_rd_dout; // replace head
            else if (push) tail_q <= mem_rd_dout;   // queue behind head
         end
         rd_two: begin
            if (pop) head_q <= tail_q; // shift up
            if (pop && push) tail_q <= mem_rd_dout;
         end
         default: ;
      endcase
   end

   assign rsp_valid = (state_q != rd_empty);
   assign rsp_data  = head_q;

   // held response must not change under back-pressure
   a_rsp_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data))
   );

endmodule

// File: source/spm_top.sv
`timescale 1ns/10ps

module spm_top #(
   parameter int  DW    = spm_pkg::spm_default_dw,    // word width
   parameter int  DEPTH = spm_pkg::spm_default_depth, // number of words
   localparam int AW    = $clog2(DEPTH),              // address width
   localparam int SW    = DW / spm_pkg::spm_byte_w    // strobe width
) (
   input  logic          clk,       // system clock
   input  logic          rst_n,     // sync reset, active low
   // write channel
   input  logic          wr_valid,
   output logic          wr_ready,
   input  logic [AW-1:0] wr_addr,
   input  logic [DW-1:0] wr_data,
   input  logic [SW-1:0] wr_strb,   // one bit per byte
   // read channel
   input  logic          rd_valid,
   output logic          rd_ready,
   input  logic [AW-1:0] rd_addr,
   // response channel
   output logic          rsp_valid,
   input  logic          rsp_ready,
   output logic [DW-1:0] rsp_data,
   // BIST, memory init
   input  logic          bist_en,
   input  logic          bist_we,
   input  logic [DW-1:0] bist_wem,
   input  logic [AW-1:0] bist_addr,
   input  logic [DW-1:0] bist_din
);

   spm_wr_if #(.DW(DW), .DEPTH(DEPTH)) wr_bus (); // write stage to memory

   logic          wr_gnt;      // memory port free
   logic          mem_rd_en;   // read stage to ram
   logic [AW-1:0] mem_rd_addr;
   logic [DW-1:0] mem_rd_dout; // ram to read stage

   spm_write_stage #(.DW(DW), .DEPTH(DEPTH)) i_wr (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_valid (wr_valid),
      .wr_ready (wr_ready),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_strb  (wr_strb),
      .wr_gnt   (wr_gnt),
      .mem      (wr_bus.src)
   );

   spm_mem_dp #(.DW(DW), .DEPTH(DEPTH)) i_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr        (wr_bus.mem),
      .wr_gnt    (wr_gnt),
      .rd_en     (mem_rd_en),
      .rd_addr   (mem_rd_addr),
      .rd_dout   (mem_rd_dout),
      .bist_en   (bist_en),
      .bist_we   (bist_we),
      .bist_wem  (bist_wem),
      .bist_addr (bist_addr),
      .bist_din  (bist_din)
   );

   spm_read_stage #(.DW(DW), .DEPTH(DEPTH)) i_rd (
      .clk         (clk),
      .rst_n       (rst_n),
      .rd_valid    (rd_valid),
      .rd_ready    (rd_ready),
      .rd_addr     (rd_addr),
      .mem_rd_en   (mem_rd_en),
      .mem_rd_addr (mem_rd_addr),
      .mem_rd_dout (mem_rd_dout),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp_data    (rsp_data)
   );

endmodule

// File: source/spm_wr_if.sv
`timescale 1ns/10ps

interface spm_wr_if #(
   parameter int  DW    = 64,             // word width
   parameter int  DEPTH = 32,             // number of words
   localparam int AW    = $clog2(DEPTH)   // address width
);

   logic          wr_en;   // write strobe, acts on the edge
   logic [DW-1:0] wr_wem;  // per bit write enable
   logic [AW-1:0] wr_addr; // word address
   logic [DW-1:0] wr_din;  // write data

   // write stage side
   modport src (
      output wr_en,
      output wr_wem,
      output wr_addr,
      output wr_din
   );

   // memory side
   modport mem (
      input wr_en,
      input wr_wem,
      input wr_addr,
      input wr_din
   );

endinterface

// File: source/spm_write_stage.sv
`timescale 1ns/10ps

module spm_write_stage #(
   parameter int  DW    = 64,                    // word width
   parameter int  DEPTH = 32,                    // number of words
   localparam int AW    = $clog2(DEPTH),         // address width
   localparam int SW    = DW / spm_pkg::spm_byte_w // strobe width
) (
   input  logic          clk,      // clock
   input  logic          rst_n,    // sync reset, active low
   input  logic          wr_valid, // request valid
   output logic          wr_ready, // request ready
   input  logic [AW-1:0] wr_addr,  // word address
   input  logic [DW-1:0] wr_data,  // write data
   input  logic [SW-1:0] wr_strb,  // byte strobes
   input  logic          wr_gnt,   // memory port free
   spm_wr_if.src         mem       // to memory write port
);

   import spm_pkg::*;

   logic          accept; // handshake this edge
   logic          pend_q; // request waiting for the ram
   logic [AW-1:0] addr_q; // held address
   logic [DW-1:0] data_q; // held data
   logic [DW-1:0] wem_d;  // expanded strobes
   logic [DW-1:0] wem_q;  // held bit mask

   assign wr_ready = wr_gnt; // no skid, just the grant
   assign accept   = wr_valid & wr_ready;

   //##################################################
   // strobe to bit mask
   //##################################################
   always_comb begin
      for (int i = 0; i < SW; i++) begin
         wem_d[i*spm_byte_w +: spm_byte_w] = {spm_byte_w{wr_strb[i]}}; // one lane
      end
   end

   //##################################################
   // request register
   //##################################################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pend_q <= 1'b0;
      end else if (wr_gnt) begin
         pend_q <= accept; // old one drains on this same edge
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= wr_addr;
         data_q <= wr_data;
         wem_q  <= wem_d;
      end
   end

   assign mem.wr_en   = pend_q & wr_gnt; // deferred while bist is active
   assign mem.wr_wem  = wem_q;
   assign mem.wr_addr = addr_q;
   assign mem.wr_din  = data_q;

   a_wr_addr_range : assert property (
      @(posedge clk) disable iff (!rst_n) accept |-> (int'(wr_addr) < DEPTH)
   );

endmodule

// File: verif/spm_checker.sv
`timescale 1ns/10ps

module spm_checker #(
   parameter int DW = 64 // word width
) (
   input logic                   clk,       // same clock as the dut
   input logic                   rst_n,     // checks idle in reset
   input logic                   rsp_valid, // response channel
   input logic                   rsp_ready,
   input logic [DW-1:0]          rsp_data,
   input logic                   wr_ready,  // write channel ready
   input logic                   bist_en,   // bist owns the write port
   input spm_pkg::spm_rd_state_e rd_state   // buffer occupancy, for messages
);

   import spm_pkg::*;

   logic [DW-1:0] exp_q [$];      // expected words, oldest first
   logic [DW-1:0] exp_w;          // word popped for this response
   int            data_errs  = 0; // wrong response words
   int            proto_errs = 0; // handshake or ordering trouble
   int            rsp_cnt    = 0; // responses taken

   function automatic void expect_word(input logic [DW-1:0] w);
      exp_q.push_back(w); // one per accepted read
   endfunction

   function automatic int pending();
      return exp_q.size(); // reads not yet answered
   endfunction

   //##################################################
   // compare on every rising edge
   //##################################################
   always @(posedge clk) begin
      if (rst_n) begin
         if (bist_en && wr_ready) begin
            $display("FAILED %0t wr_ready got %b expected 0", $time, wr_ready);
            proto_errs++;
         end
         if (rsp_valid && rsp_ready) begin
            rsp_cnt++;
            if (exp_q.size() == 0) begin
               $display("response at %0t with no read outstanding, buffer state %s",
                        $time, rd_state.name());
               proto_errs++;
            end else begin
               exp_w = exp_q.pop_front(); // strict request order
               if (rsp_data !== exp_w) begin
                  $display("FAILED %0t rsp_data got %h expected %h", $time, rsp_data, exp_w);
                  data_errs++;
               end
            end
         end
      end
   end

endmodule

// File: verif/spm_tb.sv
`timescale 1ns/10ps

module spm_tb;

   import spm_pkg::*;

   localparam int DW       = spm_default_dw;
   localparam int DEPTH    = spm_default_depth;
   localparam int AW       = $clog2(DEPTH);
   localparam int SW       = DW / spm_byte_w;
   localparam int WAIT_MAX = 200; // edges before a wait gives up
   localparam logic [DW-1:0] LANE = (1 << spm_byte_w) - 1; // one byte lane

   typedef enum logic [2:0] {k_idle, k_write, k_read, k_bist, k_both, k_block} kind_e;

   typedef struct packed {
      kind_e         kind;
      logic [AW-1:0] addr;
      logic [DW-1:0] data;
      logic [DW-1:0] mask; // bist mask, or strobes in the low bits
   } step_t;

   logic          clk;
   logic          rst_n;
   logic          wr_valid;
   logic          wr_ready;
   logic [AW-1:0] wr_addr;
   logic [DW-1:0] wr_data;
   logic [SW-1:0] wr_strb;
   logic          rd_valid;
   logic          rd_ready;
   logic [AW-1:0] rd_addr;
   logic          rsp_valid;
   logic          rsp_ready;
   logic [DW-1:0] rsp_data;
   logic          bist_en;
   logic          bist_we;
   logic [DW-1:0] bist_wem;
   logic [AW-1:0] bist_addr;
   logic [DW-1:0] bist_din;

   logic [DW-1:0] ref_mem [DEPTH]; // reference copy of the ram
   step_t         steps [$];       // stimulus table
   integer        seed;            // $random state
   logic [31:0]   rnd;             // back-pressure draw
   int            tb_errs;         // timeouts, reset values
   bit            abort;           // stop applying steps

   spm_top #(.DW(DW), .DEPTH(DEPTH)) i_dut (.*);

   spm_checker #(.DW(DW)) i_chk (
      .clk       (clk),
      .rst_n     (rst_n),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .wr_ready  (wr_ready),
      .bist_en   (bist_en),
      .rd_state  (i_dut.i_rd.state_q)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk; // 100 ns period

   always @(negedge clk) begin
      rnd       = $random(seed);
      rsp_ready = (rnd[1:0] != 2'b00); // ready about three times in four
   end

   //##################################################
   // reference model
   //##################################################
   function automatic logic [DW-1:0] lane_mask(input logic [SW-1:0] strb);
      logic [DW-1:0] m;
      m = '0;
      for (int b = 0; b < SW; b++) begin
         if (strb[b]) m = m | (LANE << (b * spm_byte_w)); // whole byte per strobe
      end
      return m;
   endfunction

   function automatic logic [DW-1:0] merge_bits(input logic [DW-1:0] old_w, new_w, mask);
      return (new_w & mask) | (old_w & ~mask); // masked bits only
   endfunction

   function automatic logic [DW-1:0] fill_word(input logic [31:0] a);
      return {32'hb157_0000 | a, (a * 32'h0101_0101) ^ 32'h5a5a_5a5a};
   endfunction

   always @(posedge clk) begin
      if (rst_n) begin
         if (bist_en && bist_we) begin
            ref_mem[bist_addr] = merge_bits(ref_mem[bist_addr], bist_din, bist_wem); // same edge
         end
         if (rd_valid && rd_ready) begin
            i_chk.expect_word(ref_mem[rd_addr]); // read-first, before this edge's write
         end
         if (wr_valid && wr_ready) begin
            ref_mem[wr_addr] = merge_bits(ref_mem[wr_addr], wr_data, lane_mask(wr_strb));
         end
      end
   end

   //##################################################
   // stimulus table
   //##################################################
   function automatic void add_step(kind_e k, int a, logic [DW-1:0] d, logic [DW-1:0] m);
      step_t s;
      s.kind = k;
      s.addr = a[AW-1:0];
      s.data = d;
      s.mask = m;
      steps.push_back(s);
   endfunction

   function automatic void build_table();
      for (int a = 0; a < DEPTH; a++) add_step(k_bist, a, fill_word(a), '1); // init all words
      add_step(k_idle, 0, '0, '0);
      for (int a = 0; a < DEPTH; a++) add_step(k_read, a, '0, '0); // bist read-back
      for (int a = 0; a < 8; a++) begin
         add_step(k_write, a, {32'hc0de_0000 | a, 32'h7e57_0000 + a}, '1); // full strobes
      end
      for (int a = 0; a < 8; a++) add_step(k_read, a, '0, '0);
      add_step(k_write, 3, 64'hffee_ddcc_bbaa_9988, 64'h05); // bytes 0 and 2
      add_step(k_write, 4, 64'h1122_3344_5566_7788, 64'ha0); // bytes 5 and 7
      add_step(k_write, 5, 64'h0f0f_0f0f_f0f0_f0f0, 64'h3c); // middle four
      add_step(k_write, 3, 64'h0, 64'h80);                   // top byte cleared
      for (int a = 3; a < 6; a++) add_step(k_read, a, '0, '0);
      add_step(k_both, 9, 64'h600d_600d_600d_600d, '1); // collision, old word back
      add_step(k_read, 9, '0, '0);                       // new word now
      add_step(k_block, 10, 64'hdead_beef_dead_beef, '1); // write held off by bist
      add_step(k_read, 10, '0, '0);
      for (int i = 0; i < 30; i++) begin
         if (i % 3 == 0) add_step(k_write, $random(seed), {$random(seed), $random(seed)},
                                  $random(seed)); // random strobes too
         else add_step(k_read, $random(seed), '0, '0);
      end
   endfunction

   //##################################################
   // drivers and waits, entered on a falling edge
   //##################################################
   task automatic note_timeout(input string what);
      if (!abort) begin
         $display("timeout at %0t waiting for %s", $time, what);
         tb_errs++;
      end
      abort = 1'b1;
   endtask

   task automatic post_write(input step_t s);
      wr_valid = 1'b1;
      wr_addr  = s.addr;
      wr_data  = s.data;
      wr_strb  = s.mask[SW-1:0];
   endtask

   task automatic post_read(input step_t s);
      rd_valid = 1'b1;
      rd_addr  = s.addr;
   endtask

   task automatic await_handshake(input logic wr_on, input logic rd_on);
      int   tries;
      logic wr_left;
      logic rd_left;
      tries   = 0;
      wr_left = wr_on;
      rd_left = rd_on;
      while ((wr_left || rd_left) && tries < WAIT_MAX) begin
         @(posedge clk);
         if (wr_ready) wr_left = 1'b0; // taken on this edge
         if (rd_ready) rd_left = 1'b0;
         tries++;
         @(negedge clk);
         wr_valid = wr_left; // drop what went through
         rd_valid = rd_left;
      end
      if (wr_left || rd_left) note_timeout(wr_left ? "write handshake" : "read handshake");
   endtask

   task automatic await_read_room();
      int tries;
      tries = 0;
      while (!rd_ready && tries < WAIT_MAX) begin
         @(negedge clk);
         tries++;
      end
      if (!rd_ready) note_timeout("read channel room");
   endtask

   task automatic apply_step(input step_t s);
      case (s.kind)
         k_write: begin
            post_write(s);
            await_handshake(1'b1, 1'b0);
         end
         k_read: begin
            post_read(s);
            await_handshake(1'b0, 1'b1);
         end
         k_both: begin
            await_read_room(); // both land on one edge
            post_write(s);
            post_read(s);
            await_handshake(1'b1, 1'b1);
         end
         k_bist: begin
            bist_en   = 1'b1;
            bist_we   = 1'b1;
            bist_addr = s.addr;
            bist_din  = s.data;
            bist_wem  = s.mask;
            @(negedge clk); // one word per edge
            bist_en   = 1'b0;
            bist_we   = 1'b0;
         end
         k_block: begin
            bist_en = 1'b1; // port owned, bist_we stays low
            post_write(s);
            repeat (4) @(negedge clk); // checker watches wr_ready here
            wr_valid = 1'b0;
            bist_en  = 1'b0;
         end
         default: @(negedge clk);
      endcase
   endtask

   task automatic finish_run();
      int total;
      total = i_chk.data_errs + i_chk.proto_errs + tb_errs;
      $display("responses %0d, data errors %0d, protocol errors %0d, other errors %0d",
               i_chk.rsp_cnt, i_chk.data_errs, i_chk.proto_errs, tb_errs);
      if (total == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   endtask

   //##################################################
   // main sequence
   //##################################################
   initial begin
      int tries;
      seed      = 32'hc091_04bc;
      tb_errs   = 0;
      abort     = 1'b0;
      rst_n     = 1'b0;
      wr_valid  = 1'b0;
      wr_addr   = '0;
      wr_data   = '0;
      wr_strb   = '0;
      rd_valid  = 1'b0;
      rd_addr   = '0;
      rsp_ready = 1'b0;
      bist_en   = 1'b0;
      bist_we   = 1'b0;
      bist_wem  = '0;
      bist_addr = '0;
      bist_din  = '0;
      build_table();
      repeat (16) @(negedge clk); // reset for 16 cycles
      rst_n = 1'b1;
      @(negedge clk);
      // outputs right after reset
      if (wr_ready !== 1'b1) begin
         $display("FAILED %0t wr_ready got %b expected 1", $time, wr_ready);
         tb_errs++;
      end
      if (rd_ready !== 1'b1) begin
         $display("FAILED %0t rd_ready got %b expected 1", $time, rd_ready);
         tb_errs++;
      end
      if (rsp_valid !== 1'b0) begin
         $display("FAILED %0t rsp_valid got %b expected 0", $time, rsp_valid);
         tb_errs++;
      end
      foreach (steps[i]) begin
         if (!abort) apply_step(steps[i]);
      end
      tries = 0;
      while ((i_chk.pending() != 0 || rsp_valid) && tries < WAIT_MAX && !abort) begin
         @(negedge clk); // let back-pressure drain
         tries++;
      end
      if (i_chk.pending() != 0 || rsp_valid) note_timeout("outstanding read responses");
      finish_run();
   end

endmodule

// File: verilog.f
source/spm_pkg.sv
source/spm_wr_if.sv
source/spm_mem_ram.sv
source/spm_mem_dp.sv
source/spm_write_stage.sv
source/spm_read_stage.sv
source/spm_top.sv
verif/spm_checker.sv
verif/spm_tb.sv
